//--- hw/memPkg.sv
//********************
// byte-lane memory package
// sizes, lane geometry and the access-mode
// encoding shared by the controller blocks
//********************

package memPkg;

	// lane geometry
	localparam int LaneCount = 8;
	localparam int LaneBits = 3;
	localparam int RowCount = 256;
	localparam int RowWidth = 8;

	// byte address covers RowCount * LaneCount bytes
	localparam int AddrWidth = RowWidth + LaneBits;

	// port data is five bytes wide
	localparam int ByteWidth = 8;
	localparam int DataWidth = 40;
	localparam int WordBytes = DataWidth / ByteWidth;

	// lane index and row index
	typedef logic [LaneBits-1:0] LaneSel;
	typedef logic [RowWidth-1:0] RowAddr;

	// access size of one request
	// ModeNone keeps the old neighborhood code, nothing moves
	typedef enum logic [1:0] {
		ModeByte = 2'b00,
		ModeHalf = 2'b01,
		ModeWord = 2'b10,
		ModeNone = 2'b11
	} accessMode;

	// one port's data word
	typedef logic [DataWidth-1:0] portData;

endpackage

//--- hw/laneIf.sv
//********************
// lane bundle of one request port
// per-lane row, write enable, write byte
// and the registered read byte
//********************

interface laneIf;

	// row each lane reads, and writes when enabled
	memPkg::RowAddr row [memPkg::LaneCount];

	// one enable bit per lane
	logic [memPkg::LaneCount-1:0] wrEn;

	// byte going into each lane
	logic [memPkg::ByteWidth-1:0] wrByte [memPkg::LaneCount];

	// byte coming back, one cycle after row was presented
	logic [memPkg::ByteWidth-1:0] rdByte [memPkg::LaneCount];

	// port steering side
	modport steer (
		output row,
		output wrEn,
		output wrByte,
		input rdByte
	);

	// lane RAM side
	modport lane (
		input row,
		input wrEn,
		input wrByte,
		output rdByte
	);

endinterface

//--- hw/laneRam.sv
//********************
// byte-wide dual-port RAM lane
// read-before-write on both ports,
// port B wins a same-row write collision
//********************

module laneRam #(
	parameter int LaneIdx = 0
) (
	input logic clk,
	laneIf.lane portA,
	laneIf.lane portB
);

	logic [memPkg::ByteWidth-1:0] mem [memPkg::RowCount];

	// registered read bytes of each side
	logic [memPkg::ByteWidth-1:0] rdA;
	logic [memPkg::ByteWidth-1:0] rdB;

	// this lane's slice of each port's bundle
	memPkg::RowAddr rowA;
	memPkg::RowAddr rowB;

	assign rowA = portA.row[LaneIdx];
	assign rowB = portB.row[LaneIdx];

	// reads take the contents from before this edge's writes
	always_ff @(posedge clk) begin
		rdA <= mem[rowA];
		rdB <= mem[rowB];
		if (portA.wrEn[LaneIdx]) begin
			mem[rowA] <= portA.wrByte[LaneIdx];
		end
		// later assignment wins, so port 1 owns a collision
		if (portB.wrEn[LaneIdx]) begin
			mem[rowB] <= portB.wrByte[LaneIdx];
		end
	end

	assign portA.rdByte[LaneIdx] = rdA;
	assign portB.rdByte[LaneIdx] = rdB;

endmodule

//--- hw/portSteer.sv
//********************
// request port steering
// rotates one port's access onto the eight
// byte lanes and merges the read bytes back
//********************

module portSteer (
	input logic clk,
	input logic rst,
	input logic [memPkg::AddrWidth-1:0] addr,
	input memPkg::accessMode mode,
	input logic write,
	input memPkg::portData dataIn,
	output memPkg::portData dataOut,
	laneIf.steer lanes
);

	// request address split into row and lane offset
	memPkg::RowAddr baseRow;
	memPkg::RowAddr nextRow;
	memPkg::LaneSel offset;

	// bytes touched by the current request
	memPkg::LaneSel byteCount;

	// write data with byte 0 in the top byte
	memPkg::portData wrJust;

	// request bytes in access order, unused slots zero
	logic [memPkg::ByteWidth-1:0] reqBytes [memPkg::LaneCount];

	// position of each lane inside the access
	memPkg::LaneSel byteIdx [memPkg::LaneCount];

	// captured for the read merge one cycle later
	memPkg::accessMode capMode;
	memPkg::LaneSel capOffset;

	// read bytes back in access order
	logic [memPkg::ByteWidth-1:0] rdOrdered [memPkg::LaneCount];
	memPkg::portData rdJust;

	// number of bytes an access of mode m spans
	function automatic memPkg::LaneSel countOf(memPkg::accessMode m);
		case (m)
			memPkg::ModeByte: countOf = memPkg::LaneSel'(1);
			memPkg::ModeHalf: countOf = memPkg::LaneSel'(2);
			memPkg::ModeWord: countOf = memPkg::LaneSel'(memPkg::WordBytes);
			default: countOf = '0;
		endcase
	endfunction

	// move the live bytes of d to the top of the word
	function automatic memPkg::portData justify(
		memPkg::accessMode m,
		memPkg::portData d
	);
		case (m)
			memPkg::ModeByte: begin
				justify = {d[memPkg::ByteWidth-1:0],
					{(memPkg::DataWidth-memPkg::ByteWidth){1'b0}}};
			end
			memPkg::ModeHalf: begin
				justify = {d[2*memPkg::ByteWidth-1:0],
					{(memPkg::DataWidth-2*memPkg::ByteWidth){1'b0}}};
			end
			memPkg::ModeWord: justify = d;
			default: justify = '0;
		endcase
	endfunction

	// reverse of justify, zero-filling the unused upper bits
	function automatic memPkg::portData unjustify(
		memPkg::accessMode m,
		memPkg::portData d
	);
		case (m)
			memPkg::ModeByte: begin
				unjustify = {{(memPkg::DataWidth-memPkg::ByteWidth){1'b0}},
					d[memPkg::DataWidth-1 -: memPkg::ByteWidth]};
			end
			memPkg::ModeHalf: begin
				unjustify = {{(memPkg::DataWidth-2*memPkg::ByteWidth){1'b0}},
					d[memPkg::DataWidth-1 -: 2*memPkg::ByteWidth]};
			end
			memPkg::ModeWord: unjustify = d;
			default: unjustify = '0;
		endcase
	endfunction

	assign baseRow = addr[memPkg::AddrWidth-1:memPkg::LaneBits];
	assign offset = addr[memPkg::LaneBits-1:0];

	// wraps past the last row back to row 0
	assign nextRow = baseRow + memPkg::RowAddr'(1);

	assign byteCount = countOf(mode);
	assign wrJust = justify(mode, dataIn);

	// slice the justified data into access-order bytes
	always_comb begin
		for (int k = 0; k < memPkg::LaneCount; k++) begin
			if (k < memPkg::WordBytes) begin
				reqBytes[k] = wrJust[memPkg::DataWidth-1-k*memPkg::ByteWidth -: memPkg::ByteWidth];
			end else begin
				reqBytes[k] = '0;
			end
		end
	end

	// lane l carries byte (l - offset) mod 8
	always_comb begin
		for (int l = 0; l < memPkg::LaneCount; l++) begin
			byteIdx[l] = memPkg::LaneSel'(l) - offset;
		end
	end

	// lanes below the offset hold bytes from the following row
	always_comb begin
		for (int l = 0; l < memPkg::LaneCount; l++) begin
			if (memPkg::LaneSel'(l) < offset) begin
				lanes.row[l] = nextRow;
			end else begin
				lanes.row[l] = baseRow;
			end
		end
	end

	// write enables and bytes, with reset forcing a no-write cycle
	always_comb begin
		for (int l = 0; l < memPkg::LaneCount; l++) begin
			lanes.wrEn[l] = write && !rst && (byteIdx[l] < byteCount);
			lanes.wrByte[l] = reqBytes[byteIdx[l]];
		end
	end

	// lane bytes arrive next cycle, keep what is needed to merge them
	always_ff @(posedge clk) begin
		if (rst) begin
			capMode <= memPkg::ModeNone;
			capOffset <= '0;
		end else begin
			capMode <= mode;
			capOffset <= offset;
		end
	end

	// rotate the lanes back so byte 0 comes first
	always_comb begin
		for (int k = 0; k < memPkg::LaneCount; k++) begin
			rdOrdered[k] = lanes.rdByte[capOffset + memPkg::LaneSel'(k)];
		end
	end

	// first five bytes form the justified read word
	always_comb begin
		rdJust = '0;
		for (int k = 0; k < memPkg::WordBytes; k++) begin
			rdJust[memPkg::DataWidth-1-k*memPkg::ByteWidth -: memPkg::ByteWidth] = rdOrdered[k];
		end
	end

	assign dataOut = unjustify(capMode, rdJust);

endmodule

//--- hw/byteBankCtl.sv
//********************
// two-port byte-lane memory controller
// each port reaches every one of the eight
// lane RAMs through its own steering block
//********************

module byteBankCtl (
	input logic clk,
	input logic rst,
	input logic [memPkg::AddrWidth-1:0] addr0,
	input logic [memPkg::AddrWidth-1:0] addr1,
	input memPkg::accessMode mode0,
	input memPkg::accessMode mode1,
	input logic write0,
	input logic write1,
	input memPkg::portData dataIn0,
	input memPkg::portData dataIn1,
	output memPkg::portData dataOut0,
	output memPkg::portData dataOut1
);

	// one lane bundle per request port
	laneIf lanes0 ();
	laneIf lanes1 ();

	// port 0 steering
	portSteer u_port0 (
		.clk(clk),
		.rst(rst),
		.addr(addr0),
		.mode(mode0),
		.write(write0),
		.dataIn(dataIn0),
		.dataOut(dataOut0),
		.lanes(lanes0.steer)
	);

	// port 1 steering
	portSteer u_port1 (
		.clk(clk),
		.rst(rst),
		.addr(addr1),
		.mode(mode1),
		.write(write1),
		.dataIn(dataIn1),
		.dataOut(dataOut1),
		.lanes(lanes1.steer)
	);

	// port 0 on side A, port 1 on side B so port 1 wins collisions
	for (genvar i = 0; i < memPkg::LaneCount; i++) begin : laneGen
		laneRam #(
			.LaneIdx(i)
		) u_lane (
			.clk(clk),
			.portA(lanes0.lane),
			.portB(lanes1.lane)
		);
	end

endmodule

//--- tests/tbClock.sv
//********************
// testbench clock and power-on reset
//********************

module tbClock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50ns clk = ~clk;
	end

	// reset held for two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- tests/byteBankCtl_checker.sv
//********************
// assertions on the controller top level
// reset blocks lane writes, narrow reads zero-fill
//********************

module byteBankCtl_checker (
	input logic clk,
	input logic rst,
	input memPkg::accessMode mode0,
	input memPkg::accessMode mode1,
	input logic [memPkg::LaneCount-1:0] wrEn0,
	input logic [memPkg::LaneCount-1:0] wrEn1,
	input memPkg::portData dataOut0,
	input memPkg::portData dataOut1
);
	timeunit 1ns;
	timeprecision 1ps;

	// no lane of either port is written while reset is high
	noWriteInReset: assert property (@(posedge clk) rst |-> (wrEn0 == '0 && wrEn1 == '0))
		else $error("lane write enable set while reset is high");

	// a byte read returns only the low byte
	byteUpperZero0: assert property (@(posedge clk) disable iff (rst)
		mode0 == memPkg::ModeByte |=> dataOut0[memPkg::DataWidth-1:memPkg::ByteWidth] == '0)
		else $error("port 0 byte read left upper bits set");

	byteUpperZero1: assert property (@(posedge clk) disable iff (rst)
		mode1 == memPkg::ModeByte |=> dataOut1[memPkg::DataWidth-1:memPkg::ByteWidth] == '0)
		else $error("port 1 byte read left upper bits set");

	// reserved mode reads as zero
	noneReadsZero0: assert property (@(posedge clk) disable iff (rst)
		mode0 == memPkg::ModeNone |=> dataOut0 == '0)
		else $error("port 0 reserved-mode read was not zero");

endmodule

bind byteBankCtl byteBankCtl_checker u_checker (
	.clk(clk),
	.rst(rst),
	.mode0(mode0),
	.mode1(mode1),
	.wrEn0(lanes0.wrEn),
	.wrEn1(lanes1.wrEn),
	.dataOut0(dataOut0),
	.dataOut1(dataOut1)
);

//--- tests/tbMonitor.sv
//********************
// response checker of the testbench
// flat shadow memory, expected read data, compare
//********************

module tbMonitor (
	input logic clk,
	input logic rst,
	input int phase,
	input logic [memPkg::AddrWidth-1:0] addr0,
	input logic [memPkg::AddrWidth-1:0] addr1,
	input memPkg::accessMode mode0,
	input memPkg::accessMode mode1,
	input logic write0,
	input logic write1,
	input memPkg::portData dataIn0,
	input memPkg::portData dataIn1,
	input memPkg::portData dataOut0,
	input memPkg::portData dataOut1,
	output int errCount,
	output int checkCount
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [memPkg::AddrWidth-1:0] byteAddr;

	// flat byte view of the memory
	// known marks bytes written so far
	logic [7:0] shadow [memPkg::RowCount * memPkg::LaneCount];
	bit known [memPkg::RowCount * memPkg::LaneCount];

	int errs = 0;
	int checks = 0;
	bit pend = 1'b0;
	string pendName;
	memPkg::portData exp0;
	memPkg::portData exp1;
	memPkg::portData care0;
	memPkg::portData care1;

	assign errCount = errs;
	assign checkCount = checks;

	function automatic int spanOf(memPkg::accessMode m);
		case (m)
			memPkg::ModeByte: return 1;
			memPkg::ModeHalf: return 2;
			memPkg::ModeWord: return 5;
			default: return 0;
		endcase
	endfunction

	function automatic string phaseName(int p);
		case (p)
			1: return "wordOffsets";
			2: return "partialWrites";
			3: return "readDuringWrite";
			4: return "collision";
			5: return "resetAndNone";
			6: return "random";
			default: return "idle";
		endcase
	endfunction

	// first byte lands in the most significant used byte
	// care keeps the zero upper bits and drops bytes never written
	function automatic memPkg::portData refRead(
		input byteAddr a,
		input memPkg::accessMode m,
		output memPkg::portData care
	);
		memPkg::portData v;
		byteAddr b;
		v = '0;
		care = '1;
		for (int k = 0; k < spanOf(m); k++) begin
			b = a + byteAddr'(k);
			v = {v[memPkg::DataWidth-9:0], shadow[b]};
			care = {care[memPkg::DataWidth-9:0], known[b] ? 8'hFF : 8'h00};
		end
		return v;
	endfunction

	function automatic void applyWrite(byteAddr a, memPkg::accessMode m, memPkg::portData d);
		byteAddr b;
		int n;
		n = spanOf(m);
		for (int k = 0; k < n; k++) begin
			b = a + byteAddr'(k);
			shadow[b] = d[8 * (n - 1 - k) +: 8];
			known[b] = 1'b1;
		end
	endfunction

	task automatic compare(input int p, input memPkg::portData act,
			input memPkg::portData exp, input memPkg::portData care);
		checks++;
		if ((act & care) !== (exp & care)) begin
			errs++;
			$display("FAIL %s port%0d: expected %h actual %h", pendName, p, exp & care, act);
		end
	endtask

	// dataOut seen here belongs to the request sampled one edge earlier
	always @(posedge clk) begin
		if (pend) begin
			compare(0, dataOut0, exp0, care0);
			compare(1, dataOut1, exp1, care1);
		end
		pend = !rst;
		pendName = phaseName(phase);
		if (!rst) begin
			exp0 = refRead(addr0, mode0, care0);
			exp1 = refRead(addr1, mode1, care1);
			// port 1 applied last so it owns a shared byte
			if (write0) applyWrite(addr0, mode0, dataIn0);
			if (write1) applyWrite(addr1, mode1, dataIn1);
		end
	end

endmodule

//--- tests/tbTop.sv
//********************
// testbench top for the byte-lane controller
// directed cases, then random two-port traffic
//********************

module tbTop;
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [memPkg::AddrWidth-1:0] byteAddr;

	localparam logic [15:0] Seed = 16'd68;
	localparam int RandomOps = 600;
	localparam int DirectedCycles = 40;
	localparam int TimeoutLimit = 2 * (DirectedCycles + RandomOps);

	logic clk;
	logic rstBoot;
	logic rstReq;
	logic rst;
	byteAddr addr0;
	byteAddr addr1;
	memPkg::accessMode mode0;
	memPkg::accessMode mode1;
	logic write0;
	logic write1;
	memPkg::portData dataIn0;
	memPkg::portData dataIn1;
	memPkg::portData dataOut0;
	memPkg::portData dataOut1;
	int phase;
	int errCount;
	int checkCount;
	int cycles = 0;
	logic [15:0] lfsrState;

	// next request of each port waiting for issue
	byteAddr stAddr [2];
	memPkg::accessMode stMode [2];
	logic stWrite [2];
	memPkg::portData stData [2];

	assign rst = rstBoot | rstReq;

	tbClock u_clock (
		.clk(clk),
		.rst(rstBoot)
	);

	byteBankCtl u_dut (.*);

	tbMonitor u_monitor (.*);

	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// lsb first, one step per bit
	function automatic memPkg::portData takeBits(int n);
		memPkg::portData v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsrState[0];
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	task automatic stage(input int p, input byteAddr a, input memPkg::accessMode m,
			input logic w, input memPkg::portData d);
		stAddr[p] = a;
		stMode[p] = m;
		stWrite[p] = w;
		stData[p] = d;
	endtask

	task automatic issue(input int ph, input bit holdRst = 1'b0);
		@(posedge clk);
		addr0 <= stAddr[0];
		mode0 <= stMode[0];
		write0 <= stWrite[0];
		dataIn0 <= stData[0];
		addr1 <= stAddr[1];
		mode1 <= stMode[1];
		write1 <= stWrite[1];
		dataIn1 <= stData[1];
		phase <= ph;
		rstReq <= holdRst;
		for (int p = 0; p < 2; p++) begin
			stage(p, '0, memPkg::ModeNone, 1'b0, '0);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutLimit) begin
			$display("timeout: run did not finish within %0d cycles", TimeoutLimit);
			$display("Errors found");
			$finish;
		end
	end

	initial begin : stimulus
		byteAddr a;
		memPkg::accessMode m;
		logic w;
		memPkg::portData d;
		addr0 = '0;
		addr1 = '0;
		mode0 = memPkg::ModeNone;
		mode1 = memPkg::ModeNone;
		write0 = 1'b0;
		write1 = 1'b0;
		dataIn0 = '0;
		dataIn1 = '0;
		rstReq = 1'b0;
		phase = 0;
		lfsrState = Seed;
		for (int p = 0; p < 2; p++) begin
			stage(p, '0, memPkg::ModeNone, 1'b0, '0);
		end
		wait (rstBoot == 1'b0);

		// words at every lane offset, read back by the other port
		for (int off = 0; off < 8; off++) begin
			stage(0, byteAddr'(17 * off), memPkg::ModeWord, 1'b1, takeBits(40));
			stage(1, byteAddr'(1024 + 17 * off), memPkg::ModeWord, 1'b1, takeBits(40));
			issue(1);
			stage(0, byteAddr'(1024 + 17 * off), memPkg::ModeWord, 1'b0, '0);
			stage(1, byteAddr'(17 * off), memPkg::ModeWord, 1'b0, '0);
			issue(1);
		end
		// wraps from the last row into row 0
		stage(0, byteAddr'(2046), memPkg::ModeWord, 1'b1, takeBits(40));
		issue(1);
		stage(1, byteAddr'(2046), memPkg::ModeWord, 1'b0, '0);
		issue(1);

		// narrow writes inside a word
		stage(0, byteAddr'(300), memPkg::ModeWord, 1'b1, takeBits(40));
		issue(2);
		stage(0, byteAddr'(301), memPkg::ModeHalf, 1'b1, takeBits(40));
		stage(1, byteAddr'(304), memPkg::ModeByte, 1'b1, takeBits(40));
		issue(2);
		stage(0, byteAddr'(300), memPkg::ModeWord, 1'b0, '0);
		stage(1, byteAddr'(301), memPkg::ModeHalf, 1'b0, '0);
		issue(2);
		stage(0, byteAddr'(304), memPkg::ModeByte, 1'b0, '0);
		stage(1, byteAddr'(303), memPkg::ModeByte, 1'b0, '0);
		issue(2);

		// same-edge read sees the old byte
		stage(0, byteAddr'(500), memPkg::ModeWord, 1'b1, takeBits(40));
		issue(3);
		stage(0, byteAddr'(502), memPkg::ModeByte, 1'b1, takeBits(40));
		stage(1, byteAddr'(500), memPkg::ModeWord, 1'b0, '0);
		issue(3);
		stage(1, byteAddr'(500), memPkg::ModeWord, 1'b0, '0);
		issue(3);

		// both ports write the same bytes
		stage(0, byteAddr'(600), memPkg::ModeWord, 1'b1, takeBits(40));
		stage(1, byteAddr'(600), memPkg::ModeWord, 1'b1, takeBits(40));
		issue(4);
		stage(0, byteAddr'(700), memPkg::ModeWord, 1'b1, takeBits(40));
		stage(1, byteAddr'(702), memPkg::ModeHalf, 1'b1, takeBits(40));
		issue(4);
		stage(0, byteAddr'(600), memPkg::ModeWord, 1'b0, '0);
		stage(1, byteAddr'(700), memPkg::ModeWord, 1'b0, '0);
		issue(4);

		// writes under reset and reserved-mode writes must not land
		stage(0, byteAddr'(800), memPkg::ModeWord, 1'b1, takeBits(40));
		issue(5);
		repeat (2) begin
			stage(0, byteAddr'(800), memPkg::ModeWord, 1'b1, takeBits(40));
			stage(1, byteAddr'(802), memPkg::ModeHalf, 1'b1, takeBits(40));
			issue(5, 1'b1);
		end
		stage(0, byteAddr'(800), memPkg::ModeWord, 1'b0, '0);
		stage(1, byteAddr'(800), memPkg::ModeNone, 1'b1, takeBits(40));
		issue(5);
		stage(0, byteAddr'(800), memPkg::ModeNone, 1'b0, '0);
		stage(1, byteAddr'(800), memPkg::ModeWord, 1'b0, '0);
		issue(5);

		// random traffic in a window that crosses the top of memory
		for (int i = 0; i < RandomOps; i++) begin
			for (int p = 0; p < 2; p++) begin
				a = byteAddr'(takeBits(8) + 40'd1920);
				m = memPkg::accessMode'(2'(takeBits(2)));
				w = 1'(takeBits(1));
				d = takeBits(40);
				stage(p, a, m, w, d);
			end
			issue(6);
		end

		// let the last reads come back
		issue(0);
		issue(0);
		@(negedge clk);

		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- byteBankCtl.f
hw/memPkg.sv
hw/laneIf.sv
hw/laneRam.sv
hw/portSteer.sv
hw/byteBankCtl.sv
tests/tbClock.sv
tests/byteBankCtl_checker.sv
tests/tbMonitor.sv
tests/tbTop.sv

//--- Makefile
# Verilator build and run of the byteBankCtl testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tbTop \
		-f byteBankCtl.f --Mdir obj_dir -o simTb
	./obj_dir/simTb > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
